/* project.f */
+incdir+.
ramPkg.sv
clientPkg.sv
byteRam.sv
memCtrl.sv
memSubsys.sv
memSubsysTb.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsysTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* memSubsysTb.sv */
`include "memCtrl_macros.svh"

module memSubsysTb
    import ramPkg::*, clientPkg::*;
();

    localparam int clkPeriod = 100;
    localparam int regionSize = 64;
    localparam int numMix = 40;
    localparam int numFetch = 20;
    localparam int numArb = 10;
    localparam int numFreeze = 40;
    // worst case with at most three frozen cycles per active one
    localparam int opBudget = 40;
    localparam int numOps = regionSize / 4 + 4 * numMix + numFetch + 2 * numArb
                            + 3 * numFreeze;
    localparam longint timeoutTime = (longint'(numOps) * opBudget + 64) * clkPeriod;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     ioBufferFull;
    fetchReqS fetchReq;
    dataReqS  dataReq;
    fetchRspS fetchRsp;
    dataRspS  dataRsp;

    logic                   active;
    logic [31:0]            lfsrState;
    logic [7:0]             model [0:regionSize-1];
    logic [`MEM_ADDR_W-1:0] regionBase;
    logic [31:0]            expData;
    logic [31:0]            expInst;
    logic                   started;
    logic                   freezeOn;
    logic                   arbMode;
    logic                   dataDoneSeen;
    int                     frozenRun;

    // timing reference
    int   cyc;
    int   startCyc;
    int   expLat;
    int   frozenCnt;
    logic busy;
    logic busyIsFetch;

    memSubsys i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fetchReq     (fetchReq),
        .i_dataReq      (dataReq),
        .o_fetchRsp     (fetchRsp),
        .o_dataRsp      (dataRsp)
    );

    always #(clkPeriod / 2) clk = ~clk;

    assign active = rdy && !ioBufferFull;

    task automatic reportFailure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first failed check");
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    function automatic int randBits(input int n);
        int i;
        int v;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
        return v;
    endfunction

    function automatic accLenE randLen();
        int r;
        r = randBits(2);
        if (r == 0) begin
            return lenByte;
        end else if (r == 1) begin
            return lenHalf;
        end
        return lenWord;
    endfunction

    function automatic int randOff(input int n);
        return randBits(6) % (regionSize - n + 1);
    endfunction

    // little-endian and zero-extended
    function automatic logic [31:0] modelRead(input int off, input accLenE len);
        int          i;
        logic [31:0] v;
        v = '0;
        for (i = 0; i < int'(len); i++) begin
            v[8*i +: 8] = model[off + i];
        end
        return v;
    endfunction

    // a request is accepted when idle and active with data first
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (active && (dataReq.en || fetchReq.en)) begin
                busy        <= 1'b1;
                startCyc    <= cyc;
                frozenCnt   <= 0;
                busyIsFetch <= !dataReq.en;
                if (!dataReq.en) begin
                    expLat <= 5;
                end else if (dataReq.isStore) begin
                    expLat <= int'(dataReq.len);
                end else begin
                    expLat <= int'(dataReq.len) + 1;
                end
            end
        end else begin
            if (!active) begin
                frozenCnt <= frozenCnt + 1;
            end
            if (dataRsp.done || fetchRsp.done) begin
                busy <= 1'b0;
            end
        end
    end

    chkIdle: assert property (@(posedge clk) disable iff (rst)
        !started |-> !fetchRsp.done && !dataRsp.done && fetchRsp.inst == '0
            && dataRsp.rdata == '0 && i_dut.ramCmd.rw == memRead && i_dut.ramCmd.addr == '0)
        else reportFailure("controller not idle before the first request");

    chkInstZero: assert property (@(posedge clk) disable iff (rst)
        !fetchRsp.done |-> fetchRsp.inst == '0)
        else reportFailure("inst not zero outside the done cycle");

    chkDataZero: assert property (@(posedge clk) disable iff (rst)
        !dataRsp.done |-> dataRsp.rdata == '0)
        else reportFailure("rdata not zero outside the done cycle");

    chkOneDone: assert property (@(posedge clk) disable iff (rst)
        !(fetchRsp.done && dataRsp.done))
        else reportFailure("both done outputs high");

    chkDoneFrozen: assert property (@(posedge clk) disable iff (rst)
        (fetchRsp.done || dataRsp.done) |-> active)
        else reportFailure("done raised in a frozen cycle");

    chkWriteFrozen: assert property (@(posedge clk) disable iff (rst)
        i_dut.ramCmd.rw == memWrite |-> active)
        else reportFailure("RAM written in a frozen cycle");

    chkRdata: assert property (@(posedge clk) disable iff (rst)
        dataRsp.done |-> dataRsp.rdata == expData)
        else reportFailure($sformatf("rdata %h, expected %h", dataRsp.rdata, expData));

    chkInst: assert property (@(posedge clk) disable iff (rst)
        fetchRsp.done |-> fetchRsp.inst == expInst)
        else reportFailure($sformatf("inst %h, expected %h", fetchRsp.inst, expInst));

    chkDataLat: assert property (@(posedge clk) disable iff (rst)
        dataRsp.done |-> busy && !busyIsFetch && (cyc - startCyc) == (expLat + frozenCnt))
        else reportFailure("data done at the wrong cycle");

    chkFetchLat: assert property (@(posedge clk) disable iff (rst)
        fetchRsp.done |-> busy && busyIsFetch && (cyc - startCyc) == (expLat + frozenCnt))
        else reportFailure("fetch done at the wrong cycle");

    chkDataPulse: assert property (@(posedge clk) disable iff (rst)
        !(dataRsp.done && $past(dataRsp.done)))
        else reportFailure("data done longer than one cycle");

    chkFetchPulse: assert property (@(posedge clk) disable iff (rst)
        !(fetchRsp.done && $past(fetchRsp.done)))
        else reportFailure("fetch done longer than one cycle");

    chkArbOrder: assert property (@(posedge clk) disable iff (rst)
        arbMode && fetchRsp.done |-> dataDoneSeen)
        else reportFailure("fetch served before the data request");

    // freeze pattern with never more than three frozen cycles in a row
    task automatic nextCycle();
        @(posedge clk);
        #10;
        if (freezeOn && frozenRun < 3) begin
            rdy = (randBits(2) != 0);
            ioBufferFull = (randBits(2) == 0);
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
        if (rdy && !ioBufferFull) begin
            frozenRun = 0;
        end else begin
            frozenRun++;
        end
    endtask

    task automatic waitDone(input logic isFetch);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = isFetch ? fetchRsp.done : dataRsp.done;
            nextCycle();
        end
    endtask

    task automatic dataOp(input logic isStore, input accLenE len, input int off);
        int          i;
        logic [31:0] wdata;
        wdata = 32'(randBits(32));
        expData = isStore ? '0 : modelRead(off, len);
        dataReq.en = 1'b1;
        dataReq.isStore = isStore;
        dataReq.len = len;
        dataReq.addr = regionBase + 17'(off);
        dataReq.wdata = isStore ? wdata : '0;
        waitDone(1'b0);
        if (isStore) begin
            for (i = 0; i < int'(len); i++) begin
                model[off + i] = wdata[8*i +: 8];
            end
        end
        dataReq = '0;
    endtask

    task automatic fetchOp(input int off);
        expInst = modelRead(off, lenWord);
        fetchReq.en = 1'b1;
        fetchReq.addr = regionBase + 17'(off);
        waitDone(1'b1);
        fetchReq = '0;
    endtask

    // load and fetch raised together
    task automatic arbOp();
        accLenE len;
        int     dOff;
        int     fOff;
        len = randLen();
        dOff = randOff(int'(len));
        fOff = randOff(4);
        expData = modelRead(dOff, len);
        expInst = modelRead(fOff, lenWord);
        dataReq.en = 1'b1;
        dataReq.isStore = 1'b0;
        dataReq.len = len;
        dataReq.addr = regionBase + 17'(dOff);
        dataReq.wdata = '0;
        fetchReq.en = 1'b1;
        fetchReq.addr = regionBase + 17'(fOff);
        arbMode = 1'b1;
        dataDoneSeen = 1'b0;
        waitDone(1'b0);
        dataDoneSeen = 1'b1;
        dataReq = '0;
        waitDone(1'b1);
        fetchReq = '0;
        arbMode = 1'b0;
    endtask

    initial begin
        #(timeoutTime);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int     n;
        int     off;
        accLenE len;
        lfsrState = 32'hb658;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        cyc = 0;
        started = 1'b0;
        freezeOn = 1'b0;
        arbMode = 1'b0;
        dataDoneSeen = 1'b0;
        frozenRun = 0;
        expData = '0;
        expInst = '0;
        regionBase = 17'(randBits(16));
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (4) nextCycle();
        started = 1'b1;

        for (n = 0; n < regionSize; n += 4) begin
            dataOp(1'b1, lenWord, n);
        end

        for (n = 0; n < numMix; n++) begin
            len = randLen();
            off = randOff(int'(len));
            dataOp(1'b1, len, off);
            // bytes on both sides of the store
            if (off > 0) begin
                dataOp(1'b0, lenByte, off - 1);
            end
            if (off + int'(len) < regionSize) begin
                dataOp(1'b0, lenByte, off + int'(len));
            end
            len = randLen();
            dataOp(1'b0, len, randOff(int'(len)));
        end

        for (n = 0; n < numFetch; n++) begin
            fetchOp(randOff(4));
        end

        for (n = 0; n < numArb; n++) begin
            arbOp();
        end

        freezeOn = 1'b1;
        for (n = 0; n < numFreeze; n++) begin
            len = randLen();
            off = randOff(int'(len));
            dataOp(1'b1, len, off);
            dataOp(1'b0, len, off);
            fetchOp(randOff(4));
        end
        freezeOn = 1'b0;
        repeat (2) nextCycle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* memSubsys.sv */
`include "memCtrl_macros.svh"

module memSubsys
    import ramPkg::*, clientPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_rdy,
    input  logic     i_ioBufferFull,
    input  fetchReqS i_fetchReq,
    input  dataReqS  i_dataReq,
    output fetchRspS o_fetchRsp,
    output dataRspS  o_dataRsp
);

    ramCmdS                 ramCmd;
    logic [`MEM_BYTE_W-1:0] ramRdata;

    memCtrl i_memCtrl (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchReq     (i_fetchReq),
        .i_dataReq      (i_dataReq),
        .o_fetchRsp     (o_fetchRsp),
        .o_dataRsp      (o_dataRsp),
        .o_ramCmd       (ramCmd),
        .i_ramRdata     (ramRdata)
    );

    // main memory
    byteRam i_byteRam (
        .clk     (clk),
        .i_cmd   (ramCmd),
        .o_rdata (ramRdata)
    );

endmodule

/* memCtrl.sv */
`include "memCtrl_macros.svh"

module memCtrl
    import ramPkg::*, clientPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,
    input  fetchReqS               i_fetchReq,
    input  dataReqS                i_dataReq,
    output fetchRspS               o_fetchRsp,
    output dataRspS                o_dataRsp,
    output ramCmdS                 o_ramCmd,
    input  logic [`MEM_BYTE_W-1:0] i_ramRdata
);

    ctrlStateE                state;
    logic [2:0]               stage;

    // latched request
    logic [`MEM_ADDR_W-1:0]   addrQ;
    accLenE                   lenQ;
    logic [`MEM_DATA_W-1:0]   wdataQ;

    // first three read bytes in little-endian order
    logic [3*`MEM_BYTE_W-1:0] asmQ;

    logic                     active;
    logic                     reading;
    logic [2:0]               lenCnt;
    logic                     lastRead;
    logic                     lastWrite;
    logic [2:0]               issueIdx;
    logic [`MEM_BYTE_W-1:0]   storeByte;

    // frozen by either level
    assign active = i_rdy && !i_ioBufferFull;

    assign reading = (state == stFetch) || (state == stLoad);
    assign lenCnt = lenQ;

    // read done comes one stage past the last issued byte
    assign lastRead = (stage == lenCnt);
    assign lastWrite = (stage + 3'd1 == lenCnt);

    assign storeByte = wdataQ[stage[1:0]*`MEM_BYTE_W +: `MEM_BYTE_W];

    // during a freeze keep presenting the last issued address
    // so the byte is read again when the freeze ends
    always_comb begin
        if (!active && stage != 3'd0) begin
            issueIdx = stage - 3'd1;
        end else begin
            issueIdx = stage;
        end
    end

    // state and stage
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            stage <= '0;
        end else if (active) begin
            case (state)
                stIdle: begin
                    stage <= '0;
                    // data side wins
                    if (i_dataReq.en) begin
                        if (i_dataReq.isStore) begin
                            state <= stStore;
                        end else begin
                            state <= stLoad;
                        end
                    end else if (i_fetchReq.en) begin
                        state <= stFetch;
                    end
                end
                stFetch, stLoad: begin
                    if (lastRead) begin
                        state <= stIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                stStore: begin
                    if (lastWrite) begin
                        state <= stIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                    stage <= '0;
                end
            endcase
        end
    end

    // request capture and byte assembly
    always_ff @(posedge clk) begin
        if (active) begin
            if (state == stIdle) begin
                if (i_dataReq.en) begin
                    addrQ  <= i_dataReq.addr;
                    lenQ   <= i_dataReq.len;
                    wdataQ <= i_dataReq.wdata;
                end else if (i_fetchReq.en) begin
                    addrQ <= i_fetchReq.addr;
                    lenQ  <= lenWord;
                end
            end else if (reading) begin
                // byte k arrives at stage k+1
                case (stage)
                    3'd1: asmQ[0*`MEM_BYTE_W +: `MEM_BYTE_W] <= i_ramRdata;
                    3'd2: asmQ[1*`MEM_BYTE_W +: `MEM_BYTE_W] <= i_ramRdata;
                    3'd3: asmQ[2*`MEM_BYTE_W +: `MEM_BYTE_W] <= i_ramRdata;
                    default: ;
                endcase
            end
        end
    end

    // RAM command
    always_comb begin
        o_ramCmd.rw    = memRead;
        o_ramCmd.addr  = '0;
        o_ramCmd.wdata = '0;
        case (state)
            stFetch, stLoad: begin
                o_ramCmd.addr = addrQ + `MEM_ADDR_W'(issueIdx);
            end
            stStore: begin
                o_ramCmd.addr  = addrQ + `MEM_ADDR_W'(stage);
                o_ramCmd.wdata = storeByte;
                if (active) begin
                    o_ramCmd.rw = memWrite;
                end
            end
            default: ;
        endcase
    end

    // replies take the last byte straight from the RAM
    always_comb begin
        o_fetchRsp = '0;
        o_dataRsp  = '0;
        if (active) begin
            if (state == stFetch && lastRead) begin
                o_fetchRsp.done = 1'b1;
                o_fetchRsp.inst = {i_ramRdata, asmQ};
            end else if (state == stLoad && lastRead) begin
                o_dataRsp.done = 1'b1;
                // zero-extend by length
                case (lenQ)
                    lenByte: o_dataRsp.rdata = `MEM_DATA_W'(i_ramRdata);
                    lenHalf: begin
                        o_dataRsp.rdata = `MEM_DATA_W'({i_ramRdata,
                                                        asmQ[`MEM_BYTE_W-1:0]});
                    end
                    default: o_dataRsp.rdata = {i_ramRdata, asmQ};
                endcase
            end else if (state == stStore && lastWrite) begin
                // done with the last write
                o_dataRsp.done = 1'b1;
            end
        end
    end

endmodule

/* byteRam.sv */
`include "memCtrl_macros.svh"

module byteRam
    import ramPkg::*;
(
    input  logic                   clk,
    input  ramCmdS                 i_cmd,
    output logic [`MEM_BYTE_W-1:0] o_rdata
);

    logic [`MEM_BYTE_W-1:0] mem [0:`MEM_DEPTH-1];

    // write at the edge
    always_ff @(posedge clk) begin
        if (i_cmd.rw == memWrite) begin
            mem[i_cmd.addr] <= i_cmd.wdata;
        end
    end

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_cmd.addr];
    end

endmodule

/* clientPkg.sv */
`include "memCtrl_macros.svh"

package clientPkg;

    // value is the number of bytes moved
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accLenE;

    // controller sequencing
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stFetch = 2'd1,
        stLoad  = 2'd2,
        stStore = 2'd3
    } ctrlStateE;

    // instruction fetch request
    typedef struct packed {
        logic                   en;
        logic [`MEM_ADDR_W-1:0] addr;
    } fetchReqS;

    // data cache request
    typedef struct packed {
        logic                   en;
        logic                   isStore;
        accLenE                 len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } dataReqS;

    // fields are zero outside the done cycle
    typedef struct packed {
        logic                   done;
        logic [`MEM_DATA_W-1:0] inst;
    } fetchRspS;

    typedef struct packed {
        logic                   done;
        logic [`MEM_DATA_W-1:0] rdata;
    } dataRspS;

endpackage

/* ramPkg.sv */
`include "memCtrl_macros.svh"

package ramPkg;

    // direction of one RAM cycle
    typedef enum logic {
        memRead  = 1'b0,
        memWrite = 1'b1
    } memRwE;

    // one byte-wide RAM cycle
    typedef struct packed {
        memRwE                  rw;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_BYTE_W-1:0] wdata;
    } ramCmdS;

endpackage

/* memCtrl_macros.svh */
`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// byte address into main memory
`define MEM_ADDR_W 17

// client word width
`define MEM_DATA_W 32

// width of one RAM location
`define MEM_BYTE_W 8

// RAM size in bytes
`define MEM_DEPTH 131072

`endif
